// File: src/npc_config.svh
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// core configuration constants

// first fetch address after reset
// also the parked data address when no access is pending
`define NPC_RESET_PC 32'h8000_0000

// ebreak, matched on the whole word
// opcode SYSTEM, funct12 = 1, all other fields zero
`define NPC_EBREAK_INST 32'h0010_0073

// architectural integer registers, x0 included
`define NPC_NUM_REGS 32

// width of a register index
// fixed by the instruction format, not by the count above
`define NPC_REG_ADDR_W 5

// bytes per instruction, the sequential pc step
`define NPC_INST_BYTES 32'd4

`endif

// File: src/npc_pkg.sv
package npc_pkg;

    // RV32I base formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    // branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // one fetched word, viewed in every format
    typedef union packed {
        logic [31:0] raw;
        inst_r_t     r;
        inst_i_t     i;
        inst_s_t     s;
        inst_b_t     b;
        inst_u_t     u;
        inst_j_t     j;
    } inst_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_SLTU = 3'd2,
        ALU_XOR  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_NE   = 3'd5
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2,
        WB_IMM = 2'd3
    } wb_sel_e;

    typedef struct packed {
        logic    reg_wen;
        wb_sel_e wb_sel;
        alu_op_e alu_op;
        logic    src1_is_pc;
        logic    src2_is_imm;
        logic    mem_read;
        logic    mem_write;
        // byte access, sb or lbu
        logic    mem_byte;
        logic    is_jal;
        logic    is_jalr;
        logic    is_bne;
        logic    halt;
    } ctrl_t;

    // data port, write lands on the next clock edge
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        write;
    } dmem_req_t;

endpackage

// File: src/inst_decode.sv
`timescale 1ns/10ps

`include "npc_config.svh"

module inst_decode (
    input  npc_pkg::inst_t inst,
    output npc_pkg::ctrl_t ctrl,
    output logic [31:0]    imm
);

    import npc_pkg::*;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // opcode and functs sit at the same place in every format
    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

    // sign extension from bit 31 in all but U
    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    always_comb begin
        // unknown words fall through as a no-op
        ctrl        = '0;
        ctrl.wb_sel = WB_ALU;
        ctrl.alu_op = ALU_ADD;
        imm         = '0;

        case (opcode)
            OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_IMM;
                imm          = imm_u;
            end
            OPC_AUIPC: begin
                // pc + U immediate through the alu
                ctrl.reg_wen     = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                imm              = imm_u;
            end
            OPC_JAL: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                ctrl.is_jal  = 1'b1;
                imm          = imm_j;
            end
            OPC_JALR: begin
                // target rs1 + imm from the alu adder
                ctrl.reg_wen     = (funct3 == 3'b000);
                ctrl.wb_sel      = WB_PC4;
                ctrl.is_jalr     = (funct3 == 3'b000);
                ctrl.src2_is_imm = 1'b1;
                imm              = imm_i;
            end
            OPC_BRANCH: begin
                // only bne, compare rs1 against rs2
                ctrl.is_bne = (funct3 == 3'b001);
                ctrl.alu_op = ALU_NE;
                imm         = imm_b;
            end
            OPC_LOAD: begin
                // lw 010, lbu 100
                ctrl.mem_read = (funct3 == 3'b010) || (funct3 == 3'b100);
                ctrl.mem_byte = (funct3 == 3'b100);
                ctrl.reg_wen  = ctrl.mem_read;
                ctrl.wb_sel   = WB_MEM;
                imm           = imm_i;
            end
            OPC_STORE: begin
                // sw 010, sb 000
                ctrl.mem_write = (funct3 == 3'b010) || (funct3 == 3'b000);
                ctrl.mem_byte  = (funct3 == 3'b000);
                imm            = imm_s;
            end
            OPC_OP_IMM: begin
                ctrl.src2_is_imm = 1'b1;
                imm              = imm_i;
                case (funct3)
                    3'b000: begin
                        ctrl.reg_wen = 1'b1;
                        ctrl.alu_op  = ALU_ADD;
                    end
                    3'b011: begin
                        ctrl.reg_wen = 1'b1;
                        ctrl.alu_op  = ALU_SLTU;
                    end
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    // funct7 bit 5 splits add from sub
                    3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b011:  ctrl.alu_op = ALU_SLTU;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            default: ctrl.reg_wen = 1'b0;
        endcase

        // ebreak only on the exact word
        ctrl.halt = (inst.raw == `NPC_EBREAK_INST);
    end

endmodule

// File: src/register_file.sv
`timescale 1ns/10ps

`include "npc_config.svh"

module register_file (
    input  logic                       clk,
    input  logic [`NPC_REG_ADDR_W-1:0] raddr1,
    input  logic [`NPC_REG_ADDR_W-1:0] raddr2,
    output logic [31:0]                rdata1,
    output logic [31:0]                rdata2,
    input  logic                       wen,
    input  logic [`NPC_REG_ADDR_W-1:0] waddr,
    input  logic [31:0]                wdata
);

    // x0 has an entry but it is never written
    logic [31:0] regs [`NPC_NUM_REGS];

    // write at the retiring edge
    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    // a write in this cycle is seen only after the edge
    assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'd0 : regs[raddr2];

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    input  npc_pkg::alu_op_e alu_op,
    output logic [31:0]      result
);

    import npc_pkg::*;

    logic [31:0] sum;
    logic [31:0] diff;

    // shared adder paths
    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_SLTU: begin
                // unsigned compare, 0 or 1
                result = {31'd0, (src1 < src2)};
            end
            ALU_XOR: begin
                result = src1 ^ src2;
            end
            ALU_OR: begin
                result = src1 | src2;
            end
            ALU_NE: begin
                // 1 means bne is taken
                result = {31'd0, (diff != 32'd0)};
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

endmodule

// File: src/lsu.sv
`timescale 1ns/10ps

`include "npc_config.svh"

module lsu (
    input  logic [31:0]         base,
    input  logic [31:0]         imm,
    input  logic [31:0]         store_data,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                mem_byte,
    input  logic                enable,
    output npc_pkg::dmem_req_t  dmem_req,
    input  logic [31:0]         dmem_rdata,
    output logic [31:0]         load_data
);

    logic [31:0] eff_addr;
    logic [1:0]  lane;
    logic [7:0]  load_byte;

    // effective byte address
    assign eff_addr = base + imm;
    assign lane     = eff_addr[1:0];

    // park the address on the reset vector when idle
    // byte address kept whole, lane also shows in the mask
    assign dmem_req.addr = (mem_read || mem_write) ? eff_addr : `NPC_RESET_PC;

    // sb moves the byte into its lane, sw passes the word
    assign dmem_req.wdata = mem_byte ? ({24'd0, store_data[7:0]} << {lane, 3'b000})
                                     : store_data;

    // one-hot for sb, full for sw, none when not storing
    assign dmem_req.wmask = !mem_write ? 4'b0000 :
                            mem_byte   ? (4'b0001 << lane) :
                                         4'b1111;

    // no write in reset or after halt
    assign dmem_req.write = mem_write && enable;

    // lbu picks the addressed lane
    assign load_byte = dmem_rdata[{lane, 3'b000} +: 8];

    // zero extend for lbu, whole word for lw
    assign load_data = !mem_read ? 32'd0 :
                       mem_byte  ? {24'd0, load_byte} :
                                   dmem_rdata;

endmodule

// File: src/npc.sv
`timescale 1ns/10ps

`include "npc_config.svh"

module npc (
    input  logic                clk,
    input  logic                reset,
    output logic [31:0]         imem_addr,
    input  logic [31:0]         imem_rdata,
    output npc_pkg::dmem_req_t  dmem_req,
    input  logic [31:0]         dmem_rdata,
    output logic                halt
);

    import npc_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    inst_t       inst;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        write_enable;
    logic        branch_taken;

    // fetch is combinational off the pc
    assign imem_addr = pc;
    assign inst      = inst_t'(imem_rdata);

    inst_decode i_inst_decode (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    // fetched ebreak keeps halt up, pc holds so it stays fetched
    assign halt = ctrl.halt;

    // every architectural write blocked in reset and on halt
    assign write_enable = !reset && !ctrl.halt;

    register_file i_register_file (
        .clk    (clk),
        .raddr1 (inst.r.rs1),
        .raddr2 (inst.r.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (ctrl.reg_wen && write_enable),
        .waddr  (inst.r.rd),
        .wdata  (wb_data)
    );

    // operand muxes
    assign alu_src1 = ctrl.src1_is_pc  ? pc  : rs1_data;
    assign alu_src2 = ctrl.src2_is_imm ? imm : rs2_data;

    alu i_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .alu_op (ctrl.alu_op),
        .result (alu_result)
    );

    lsu i_lsu (
        .base       (rs1_data),
        .imm        (imm),
        .store_data (rs2_data),
        .mem_read   (ctrl.mem_read),
        .mem_write  (ctrl.mem_write),
        .mem_byte   (ctrl.mem_byte),
        .enable     (write_enable),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    // link value and pc-relative target
    assign pc_plus4     = pc + `NPC_INST_BYTES;
    assign pc_target    = pc + imm;
    assign branch_taken = ctrl.is_bne && (alu_result == 32'd1);

    // priority halt, jalr, jal or taken bne, then sequential
    always_comb begin
        if (ctrl.halt) begin
            next_pc = pc;
        end else if (ctrl.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (ctrl.is_jal || branch_taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            WB_IMM:  wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    // one instruction retires per edge
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `NPC_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: sim/npc_mem_model.sv
`timescale 1ns/10ps

module npc_mem_model (
    input  logic               clk,
    input  logic [31:0]        imem_addr,
    output logic [31:0]        imem_rdata,
    input  npc_pkg::dmem_req_t dmem_req,
    output logic [31:0]        dmem_rdata
);

    // 4 KiB window, code at 0x8000_0000 and data at 0x400 up share it
    localparam int DEPTH = 1024;

    logic [31:0] mem [DEPTH];

    // both ports read combinationally, word index from bits 11:2
    assign imem_rdata = mem[imem_addr[11:2]];
    assign dmem_rdata = mem[dmem_req.addr[11:2]];

    // masked store lands on the retiring edge
    always @(posedge clk) begin
        if (dmem_req.write) begin
            if (dmem_req.wmask[0]) mem[dmem_req.addr[11:2]][7:0]   <= dmem_req.wdata[7:0];
            if (dmem_req.wmask[1]) mem[dmem_req.addr[11:2]][15:8]  <= dmem_req.wdata[15:8];
            if (dmem_req.wmask[2]) mem[dmem_req.addr[11:2]][23:16] <= dmem_req.wdata[23:16];
            if (dmem_req.wmask[3]) mem[dmem_req.addr[11:2]][31:24] <= dmem_req.wdata[31:24];
        end
    end

    // background words, every one different
    task automatic fill_pattern();
        int          i;
        logic [31:0] byte_addr;
        for (i = 0; i < DEPTH; i++) begin
            byte_addr = 32'(i) << 2;
            mem[i] <= {~byte_addr[15:0], byte_addr[15:0]} ^ 32'h5a5a_0000;
        end
    endtask

    // one word at a byte address
    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] <= data;
    endtask

endmodule

// File: sim/npc_tb.sv
`timescale 1ns/10ps

`include "npc_config.svh"

module npc_tb;

    import npc_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 5;

    // sw x0, 0x400(x0), fetched while reset is high
    localparam logic [31:0] RESET_STORE_INST = 32'h4000_2023;

    // one memory word as read from the cases file
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } word_rec_t;

    // expected data port write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
    } store_rec_t;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        halt;

    // all cases, tagged with their case number
    word_rec_t   prog_q[$];
    int          prog_case[$];
    word_rec_t   data_q[$];
    int          data_case[$];
    store_rec_t  store_q[$];
    int          store_case[$];
    logic [31:0] halt_pc_q[$];

    // stores still awaited in the running case
    store_rec_t  exp_stores[$];
    int          store_idx;
    int          errors;
    int          watchdog_cycles;

    npc i_npc (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    npc_mem_model i_mem (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        errors++;
        $display("Error at time %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // byte enables widened to a bit mask
    function automatic logic [31:0] lane_mask(input logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    task automatic load_cases();
        int          fd;
        int          code;
        int          count;
        int          k;
        int          done;
        logic [7:0]  tag;
        string       rest;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        word_rec_t   wrec;
        store_rec_t  srec;
        fd = $fopen("sim/npc_cases.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open sim/npc_cases.txt");
        end else begin
            done = 0;
            while (done == 0) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1) begin
                    done = 1;
                end else begin
                    case (tag)
                        // rest of the line is a comment
                        "#": code = $fgets(rest, fd);
                        "P": begin
                            code = $fscanf(fd, "%h %d", addr, count);
                            if (code != 2) stop_with_error("bad program record");
                            for (k = 0; k < count; k++) begin
                                code = $fscanf(fd, "%h", data);
                                if (code != 1) stop_with_error("program record too short");
                                wrec.addr = addr + 32'(k * 4);
                                wrec.data = data;
                                prog_q.push_back(wrec);
                                prog_case.push_back(halt_pc_q.size());
                            end
                        end
                        "D": begin
                            code = $fscanf(fd, "%h %h", addr, data);
                            if (code != 2) stop_with_error("bad data record");
                            wrec.addr = addr;
                            wrec.data = data;
                            data_q.push_back(wrec);
                            data_case.push_back(halt_pc_q.size());
                        end
                        "S": begin
                            code = $fscanf(fd, "%h %h %h", addr, data, mask);
                            if (code != 3) stop_with_error("bad store record");
                            srec.addr = addr;
                            srec.data = data;
                            srec.mask = mask;
                            store_q.push_back(srec);
                            store_case.push_back(halt_pc_q.size());
                        end
                        "H": begin
                            // halt pc closes the case
                            code = $fscanf(fd, "%h", addr);
                            if (code != 1) stop_with_error("bad halt record");
                            halt_pc_q.push_back(addr);
                        end
                        default: stop_with_error("unknown record type in the cases file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // clock through reset, pc parked on the reset vector and no data write
    task automatic hold_in_reset(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            @(negedge clk);
            check_value("imem_addr", imem_addr, `NPC_RESET_PC);
            check_value("dmem_req.write", {31'd0, dmem_req.write}, 32'd0);
        end
    endtask

    task automatic run_case(input int idx);
        int k;
        @(negedge clk);
        reset = 1'b1;
        // fresh memory image, a store sits on the reset vector first
        i_mem.fill_pattern();
        i_mem.load_word(`NPC_RESET_PC, RESET_STORE_INST);
        hold_in_reset(RESET_CYCLES / 2);
        // program and data replace it while the core still sits in reset
        for (k = 0; k < prog_q.size(); k++) begin
            if (prog_case[k] == idx) i_mem.load_word(prog_q[k].addr, prog_q[k].data);
        end
        for (k = 0; k < data_q.size(); k++) begin
            if (data_case[k] == idx) i_mem.load_word(data_q[k].addr, data_q[k].data);
        end
        exp_stores.delete();
        for (k = 0; k < store_q.size(); k++) begin
            if (store_case[k] == idx) exp_stores.push_back(store_q[k]);
        end
        hold_in_reset(RESET_CYCLES - RESET_CYCLES / 2);
        reset = 1'b0;
        // run until ebreak is fetched, watchdog bounds this
        @(negedge clk);
        while (!halt) @(negedge clk);
        check_value("imem_addr", imem_addr, halt_pc_q[idx]);
        if (store_idx != exp_stores.size()) begin
            stop_with_error($sformatf("case %0d halted after %0d of %0d stores",
                                      idx, store_idx, exp_stores.size()));
        end
        // pc and halt frozen afterwards
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("halt", {31'd0, halt}, 32'd1);
            check_value("imem_addr", imem_addr, halt_pc_q[idx]);
        end
    endtask

    // store monitor, inputs sampled before the edge updates them
    always @(posedge clk) begin
        if (reset) begin
            store_idx <= 0;
        end else if (dmem_req.write) begin
            if (store_idx >= exp_stores.size()) begin
                stop_with_error($sformatf("unexpected store to address %h", dmem_req.addr));
            end else begin
                check_value("dmem_req.addr", dmem_req.addr, exp_stores[store_idx].addr);
                check_value("dmem_req.wmask", {28'd0, dmem_req.wmask},
                            {28'd0, exp_stores[store_idx].mask});
                // only enabled lanes matter
                check_value("dmem_req.wdata",
                            dmem_req.wdata & lane_mask(exp_stores[store_idx].mask),
                            exp_stores[store_idx].data & lane_mask(exp_stores[store_idx].mask));
                store_idx <= store_idx + 1;
            end
        end
    end

    // budget from the total program size
    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        stop_with_error($sformatf("core never halted within %0d cycles", watchdog_cycles));
    end

    initial begin : main_flow
        int case_idx;
        clk             = 1'b0;
        reset           = 1'b1;
        errors          = 0;
        watchdog_cycles = 0;
        load_cases();
        if (halt_pc_q.size() == 0) stop_with_error("no cases found in the cases file");
        watchdog_cycles = 4 * prog_q.size() + 100;
        for (case_idx = 0; case_idx < halt_pc_q.size(); case_idx++) begin
            run_case(case_idx);
        end
        if (errors == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "%0d errors", errors);
        end
    end

endmodule

// File: sim/npc_cases.txt
# P addr n w0 .. : n program words from addr up (n decimal), D addr word : initial data word
# S addr data mask : expected store in order, H pc : expected halt pc, closes the case
# case 0, alu ops, x0 write, lui and auipc, results stored from 0x400 up
P 80000000 27
00500093 ffd00113 002081b3 40208233 0020c2b3 0020e333 0020b3b3 00113433
0060b493 fff13513 00708013 001005b3 12345637 00010697 40302023 40402223
40502423 40602623 40702823 40802a23 40902c23 40a02e23 42002023 42b02223
42c02423 42d02623 00100073
S 00000400 00000002 f   S 00000404 00000008 f
S 00000408 fffffff8 f   S 0000040c fffffffd f
S 00000410 00000001 f   S 00000414 00000000 f
S 00000418 00000001 f   S 0000041c 00000001 f
S 00000420 00000000 f   S 00000424 00000005 f
S 00000428 12345000 f   S 0000042c 80010034 f
H 80000068
# case 1, jal, jalr, bne taken and not taken, backward loop
# stores to 400, 404 and 408 sit on skipped paths
P 80000000 17
00100093 0080016f 40102023 00000197 00c18267 40102223 00009463 40102423
00001463 40202623 40402823 40302a23 00300293 fff28293 fe029ee3 40502c23
00100073
S 0000040c 80000008 f   S 00000410 80000014 f
S 00000414 8000000c f   S 00000418 00000000 f
H 80000040
# case 2, lbu of every lane, lw, sb per lane, readback
P 80000000 21
48004083 48104103 48204183 48304203 48604283 48402303 44102023 44202223
44302423 44402623 44502823 44602a23 46100023 462000a3 46300123 464001a3
46002383 46702223 46304403 46802423 00100073
D 00000480 a1b2c3d4
D 00000484 7f80017e
S 00000440 000000d4 f   S 00000444 000000c3 f
S 00000448 000000b2 f   S 0000044c 000000a1 f
S 00000450 00000080 f   S 00000454 7f80017e f
S 00000460 000000d4 1   S 00000461 0000c300 2
S 00000462 00b20000 4   S 00000463 a1000000 8
S 00000464 a1b2c3d4 f   S 00000468 000000a1 f
H 80000050

// File: vlog.f
+incdir+src/
src/npc_pkg.sv
src/inst_decode.sv
src/register_file.sv
src/alu.sv
src/lsu.sv
src/npc.sv
sim/npc_mem_model.sv
sim/npc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the npc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module npc_tb -o npc_tb_sim

# a failing run exits non-zero, the log decides the result
./obj_dir/npc_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
